// ==== Bender.yml ====
package:
  name: digital_core

sources:
  - include_dirs:
      - include
    files:
      - design/adc_pkg.sv
      - design/prbs_pkg.sv
      - design/adc_slicer.sv
      - design/prbs_checker.sv
      - design/err_report_sender.sv
      - design/digital_core.sv

  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_digital_core.sv

// ==== design/adc_pkg.sv ====
`include "core_settings.svh"

package adc_pkg;

    // raw magnitude out of one slice
    typedef logic [`NADC-1:0] adc_code_t;

    // one frame, slice 0 in the low position
    typedef adc_code_t [`NTI-1:0] adc_frame_t;

    // unfolded and offset-corrected value
    // two extra bits cover the sign and the offset subtraction
    typedef logic signed [`NADC+1:0] slice_val_t;

    // programmable offset and decision threshold
    typedef logic signed [`NADC:0] offset_t;
    typedef logic signed [`NADC:0] thresh_t;

endpackage

// ==== design/adc_slicer.sv ====
`include "core_settings.svh"

module adc_slicer (
    input  wire logic               clk_adc,
    input  wire logic               rst_n_i,
    input  wire logic               frame_valid_i,
    input  wire adc_pkg::adc_frame_t adc_code_i,
    input  wire prbs_pkg::bits_t    adc_sign_i,
    input  wire adc_pkg::offset_t   offset_i,
    input  wire adc_pkg::thresh_t   thresh_i,
    output logic                    bits_valid_o,
    output prbs_pkg::bits_t         bits_o
);

    prbs_pkg::bits_t bits_d;

    genvar k;
    generate
        for (k = 0; k < `NTI; k = k + 1) begin : g_slice
            adc_pkg::slice_val_t mag;
            adc_pkg::slice_val_t unfolded;
            adc_pkg::slice_val_t corrected;

            // zero-extend the magnitude before it becomes signed
            assign mag = adc_pkg::slice_val_t'({2'b00, adc_code_i[k]});

            // sign bit set means a positive sample
            assign unfolded = adc_sign_i[k] ? mag : -mag;

            assign corrected = unfolded - offset_i;

            // strict compare, a value equal to the threshold decides 0
            assign bits_d[k] = (corrected > thresh_i);
        end
    endgenerate

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bits_valid_o <= 1'b0;
        end else begin
            bits_valid_o <= frame_valid_i;
        end
    end

    // decided bits only move when a frame arrives
    always_ff @(posedge clk_adc) begin
        if (frame_valid_i) begin
            bits_o <= bits_d;
        end
    end

endmodule

// ==== design/digital_core.sv ====
module digital_core (
    input  wire logic                 clk_adc,
    input  wire logic                 rst_n_i,
    input  wire logic                 frame_valid_i,
    input  wire adc_pkg::adc_frame_t  adc_code_i,
    input  wire prbs_pkg::bits_t      adc_sign_i,
    input  wire adc_pkg::offset_t     offset_i,
    input  wire adc_pkg::thresh_t     thresh_i,
    input  wire prbs_pkg::chan_mask_t chan_sel_i,
    input  wire logic                 credit_i,
    output wire logic                 report_valid_o,
    output wire prbs_pkg::count_t     err_count_o,
    output wire prbs_pkg::count_t     bit_count_o,
    output wire prbs_pkg::frame_cnt_t frame_count_o
);

    // slicer to checker
    wire logic             bits_valid;
    wire prbs_pkg::bits_t  bits;

    // checker to report sender
    wire logic             cnt_valid;
    wire prbs_pkg::count_t frame_err;
    wire prbs_pkg::count_t frame_bits;

    adc_slicer slicer_i (
        .clk_adc       (clk_adc),
        .rst_n_i       (rst_n_i),
        .frame_valid_i (frame_valid_i),
        .adc_code_i    (adc_code_i),
        .adc_sign_i    (adc_sign_i),
        .offset_i      (offset_i),
        .thresh_i      (thresh_i),
        .bits_valid_o  (bits_valid),
        .bits_o        (bits)
    );

    prbs_checker checker_i (
        .clk_adc      (clk_adc),
        .rst_n_i      (rst_n_i),
        .bits_valid_i (bits_valid),
        .bits_i       (bits),
        .chan_sel_i   (chan_sel_i),
        .cnt_valid_o  (cnt_valid),
        .frame_err_o  (frame_err),
        .frame_bits_o (frame_bits)
    );

    err_report_sender sender_i (
        .clk_adc        (clk_adc),
        .rst_n_i        (rst_n_i),
        .cnt_valid_i    (cnt_valid),
        .frame_err_i    (frame_err),
        .frame_bits_i   (frame_bits),
        .credit_i       (credit_i),
        .report_valid_o (report_valid_o),
        .err_count_o    (err_count_o),
        .bit_count_o    (bit_count_o),
        .frame_count_o  (frame_count_o)
    );

endmodule

// ==== design/err_report_sender.sv ====
`include "core_settings.svh"

module err_report_sender (
    input  wire logic             clk_adc,
    input  wire logic             rst_n_i,
    input  wire logic             cnt_valid_i,
    input  wire prbs_pkg::count_t frame_err_i,
    input  wire prbs_pkg::count_t frame_bits_i,
    input  wire logic             credit_i,
    output logic                  report_valid_o,
    output prbs_pkg::count_t      err_count_o,
    output prbs_pkg::count_t      bit_count_o,
    output prbs_pkg::frame_cnt_t  frame_count_o
);

    // one spare code so an excess credit return is visible
    localparam int CRED_W = $clog2(`CREDITS_INIT + 1) + 1;

    prbs_pkg::count_t     err_sum;
    prbs_pkg::count_t     bit_sum;
    prbs_pkg::frame_cnt_t frame_sum;
    logic [CRED_W-1:0]    credits;

    // sums including a frame arriving this cycle
    prbs_pkg::count_t     err_next;
    prbs_pkg::count_t     bit_next;
    prbs_pkg::frame_cnt_t frame_next;

    logic due;
    logic send;

    assign err_next   = err_sum + (cnt_valid_i ? frame_err_i : '0);
    assign bit_next   = bit_sum + (cnt_valid_i ? frame_bits_i : '0);
    assign frame_next = frame_sum + prbs_pkg::frame_cnt_t'(cnt_valid_i);

    // without credits the window keeps growing past its length
    assign due  = (frame_next >= prbs_pkg::frame_cnt_t'(`WINDOW_FRAMES));
    assign send = due && (credits != '0);

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_sum        <= '0;
            bit_sum        <= '0;
            frame_sum      <= '0;
            credits        <= CRED_W'(`CREDITS_INIT);
            report_valid_o <= 1'b0;
        end else begin
            report_valid_o <= send;
            if (send) begin
                err_sum   <= '0;
                bit_sum   <= '0;
                frame_sum <= '0;
            end else begin
                err_sum   <= err_next;
                bit_sum   <= bit_next;
                frame_sum <= frame_next;
            end
            // spend and return in one cycle cancel out
            case ({send, credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // report payload, held until the next send
    always_ff @(posedge clk_adc) begin
        if (send) begin
            err_count_o   <= err_next;
            bit_count_o   <= bit_next;
            frame_count_o <= frame_next;
        end
    end

    // receiver returns at most what it was sent
    credit_bound_a: assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        credits <= CRED_W'(`CREDITS_INIT));

    // every report was backed by a credit the cycle before
    report_credit_a: assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        report_valid_o |-> ($past(credits) != '0));

endmodule

// ==== design/prbs_checker.sv ====
`include "core_settings.svh"

module prbs_checker (
    input  wire logic                clk_adc,
    input  wire logic                rst_n_i,
    input  wire logic                bits_valid_i,
    input  wire prbs_pkg::bits_t     bits_i,
    input  wire prbs_pkg::chan_mask_t chan_sel_i,
    output logic                     cnt_valid_o,
    output prbs_pkg::count_t         frame_err_o,
    output prbs_pkg::count_t         frame_bits_o
);

    // last NPRBS bits of the previous frame, most recent in the top position
    logic [`NPRBS-1:0] hist;

    // set once the history holds a full frame's tail
    logic primed;

    // previous tail below the current frame, stream order from bit 0 up
    logic [`NTI+`NPRBS-1:0] stream;

    prbs_pkg::bits_t  predict;
    prbs_pkg::bits_t  err_vec;
    prbs_pkg::count_t err_sum;
    prbs_pkg::count_t bit_sum;

    assign stream = {bits_i, hist};

    genvar k;
    generate
        for (k = 0; k < `NTI; k = k + 1) begin : g_pred
            // slice k sits at NPRBS+k in the stream
            assign predict[k] = stream[`NPRBS + k - prbs_pkg::TAP_A]
                              ^ stream[`NPRBS + k - prbs_pkg::TAP_B];
        end
    endgenerate

    assign err_vec = bits_i ^ predict;

    // masked population counts
    always_comb begin
        err_sum = '0;
        bit_sum = '0;
        for (int i = 0; i < `NTI; i++) begin
            if (chan_sel_i[i]) begin
                bit_sum = bit_sum + prbs_pkg::count_t'(1);
                if (err_vec[i]) begin
                    err_sum = err_sum + prbs_pkg::count_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            primed      <= 1'b0;
            cnt_valid_o <= 1'b0;
        end else begin
            // first frame after reset only fills the history
            cnt_valid_o <= bits_valid_i && primed;
            if (bits_valid_i) begin
                primed <= 1'b1;
            end
        end
    end

    // every bit enters the history, masked or not
    always_ff @(posedge clk_adc) begin
        if (bits_valid_i) begin
            hist         <= bits_i[`NTI-1:`NTI-`NPRBS];
            frame_err_o  <= err_sum;
            frame_bits_o <= bit_sum;
        end
    end

    // a masked error implies a counted bit on the same channel
    err_le_bits_a: assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        cnt_valid_o |-> (frame_err_o <= frame_bits_o));

endmodule

// ==== design/prbs_pkg.sv ====
`include "core_settings.svh"

package prbs_pkg;

    // channel enables for the error counters
    typedef logic [`NTI-1:0] chan_mask_t;

    // decided bits of one frame, slice 0 first in the stream
    typedef logic [`NTI-1:0] bits_t;

    // frames covered by one report
    typedef logic [15:0] frame_cnt_t;

    // error and bit counts
    typedef logic [`CNT_W-1:0] count_t;

    // PRBS7 recurrence, x^7 + x^6 + 1
    // each bit equals the xor of the bits 6 and 7 positions earlier
    localparam int TAP_A = 6;
    localparam int TAP_B = 7;

endpackage

// ==== include/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// magnitude bits per ADC slice, sign travels separately
`define NADC 8

// time-interleaved slices in one frame
`define NTI 16

// order of the checked PRBS
`define NPRBS 7

// frames collected before a report is due
`define WINDOW_FRAMES 32

// credits the report receiver grants after reset
`define CREDITS_INIT 2

// width of the error and bit counters in a report
`define CNT_W 32

`endif

// ==== list.f ====
+incdir+include
design/adc_pkg.sv
design/prbs_pkg.sv
design/adc_slicer.sv
design/prbs_checker.sv
design/err_report_sender.sv
design/digital_core.sv
tests/tb_digital_core.sv

// ==== tests/tb_digital_core.sv ====
`include "core_settings.svh"

module tb_digital_core;
    timeunit 1ns;
    timeprecision 1ps;

    // frames per test phase, the first clean frame only primes the checker
    localparam int P_CLEAN    = 97;
    localparam int P_INJECT   = 128;
    localparam int P_MASKED   = 128;
    localparam int P_HOLD     = 160;
    localparam int P_RELEASE  = 64;
    localparam int TOTAL_FRAMES = P_CLEAN + P_INJECT + P_MASKED + P_HOLD + P_RELEASE;
    localparam int TIME_LIMIT = TOTAL_FRAMES * 4 * 4 + 1000;

    logic                 clk_adc;
    logic                 rst_n_i;
    logic                 frame_valid_i;
    adc_pkg::adc_frame_t  adc_code_i;
    prbs_pkg::bits_t      adc_sign_i;
    adc_pkg::offset_t     offset_i;
    adc_pkg::thresh_t     thresh_i;
    prbs_pkg::chan_mask_t chan_sel_i;
    logic                 credit_i;
    logic                 report_valid_o;
    prbs_pkg::count_t     err_count_o;
    prbs_pkg::count_t     bit_count_o;
    prbs_pkg::frame_cnt_t frame_count_o;

    // stimulus state
    logic [31:0]          rng;
    logic [`NPRBS-1:0]    gen_hist;
    adc_pkg::offset_t     offset_val;
    adc_pkg::thresh_t     thresh_val;
    prbs_pkg::chan_mask_t mask_val;

    // reference model state, tail kept oldest bit first
    logic [`NPRBS-1:0]    ref_tail;
    logic                 ref_primed;
    prbs_pkg::count_t     exp_err_q[$];
    prbs_pkg::count_t     exp_bits_q[$];

    // report bookkeeping shared by the compare and credit processes
    int   owed;
    int   hold_reports;
    int   total_err_reported;
    logic hold_credits;
    logic exact_window;
    logic expect_big;
    logic reset_check;

    digital_core DUT (
        .clk_adc        (clk_adc),
        .rst_n_i        (rst_n_i),
        .frame_valid_i  (frame_valid_i),
        .adc_code_i     (adc_code_i),
        .adc_sign_i     (adc_sign_i),
        .offset_i       (offset_i),
        .thresh_i       (thresh_i),
        .chan_sel_i     (chan_sel_i),
        .credit_i       (credit_i),
        .report_valid_o (report_valid_o),
        .err_count_o    (err_count_o),
        .bit_count_o    (bit_count_o),
        .frame_count_o  (frame_count_o)
    );

    initial begin
        clk_adc = 1'b0;
        forever #2 clk_adc = ~clk_adc;
    end

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_count(input string name, input prbs_pkg::count_t expected,
                               input prbs_pkg::count_t actual);
        if (actual !== expected) begin
            fail_now($sformatf("Error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_frames(input string name, input prbs_pkg::frame_cnt_t expected,
                                input prbs_pkg::frame_cnt_t actual);
        if (actual !== expected) begin
            fail_now($sformatf("Error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // decision rule of one slice, sign 1 is positive
    function automatic logic slice_bit(input adc_pkg::adc_code_t code, input logic sign,
                                       input adc_pkg::offset_t off, input adc_pkg::thresh_t th);
        int v;
        v = sign ? int'(code) : -int'(code);
        v = v - int'(off);
        return v > int'(th);
    endfunction

    // reference for one frame, returns 0 while the history is still empty
    function automatic logic ref_frame(input adc_pkg::adc_frame_t codes,
                                       input prbs_pkg::bits_t signs,
                                       input prbs_pkg::chan_mask_t mask,
                                       output prbs_pkg::count_t err,
                                       output prbs_pkg::count_t nbits);
        logic [`NPRBS+`NTI-1:0] s;
        logic                   pred;
        logic                   was_primed;
        int                     j;
        for (int i = 0; i < `NPRBS; i++) begin
            s[i] = ref_tail[i];
        end
        for (int k = 0; k < `NTI; k++) begin
            s[`NPRBS + k] = slice_bit(codes[k], signs[k], offset_val, thresh_val);
        end
        err = '0;
        nbits = '0;
        for (int k = 0; k < `NTI; k++) begin
            j = `NPRBS + k;
            pred = s[j - prbs_pkg::TAP_A] ^ s[j - prbs_pkg::TAP_B];
            if (mask[k]) begin
                nbits = nbits + 1;
                if (s[j] != pred) begin
                    err = err + 1;
                end
            end
        end
        for (int i = 0; i < `NPRBS; i++) begin
            ref_tail[i] = s[`NTI + i];
        end
        was_primed = ref_primed;
        ref_primed = 1'b1;
        return was_primed;
    endfunction

    // PRBS7 source, bit 0 of the history is the newest
    task automatic next_prbs_bit(output logic b);
        b = gen_hist[prbs_pkg::TAP_A-1] ^ gen_hist[prbs_pkg::TAP_B-1];
        gen_hist = {gen_hist[`NPRBS-2:0], b};
    endtask

    task automatic draw_slice(input logic want, output adc_pkg::adc_code_t code,
                              output logic sign);
        int   tries;
        logic found;
        tries = 0;
        found = 1'b0;
        while (!found) begin
            rng = xorshift32(rng);
            code = rng[`NADC-1:0];
            sign = rng[`NADC];
            found = (slice_bit(code, sign, offset_val, thresh_val) == want);
            tries++;
            if (tries > 1000) begin
                fail_now("no ADC code could be found that slices to the wanted bit");
            end
        end
    endtask

    task automatic send_frames(input int n, input logic inject);
        adc_pkg::adc_frame_t codes;
        prbs_pkg::bits_t     signs;
        prbs_pkg::count_t    e;
        prbs_pkg::count_t    nb;
        adc_pkg::adc_code_t  c;
        logic                sg;
        logic                b;
        for (int f = 0; f < n; f++) begin
            for (int k = 0; k < `NTI; k++) begin
                next_prbs_bit(b);
                if (inject) begin
                    rng = xorshift32(rng);
                    // roughly one slice in forty is flipped
                    if (rng[7:0] < 8'd6) begin
                        b = ~b;
                    end
                end
                draw_slice(b, c, sg);
                codes[k] = c;
                signs[k] = sg;
            end
            if (ref_frame(codes, signs, mask_val, e, nb)) begin
                exp_err_q.push_back(e);
                exp_bits_q.push_back(nb);
            end
            @(posedge clk_adc);
            frame_valid_i <= 1'b1;
            adc_code_i    <= codes;
            adc_sign_i    <= signs;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_adc);
            frame_valid_i <= 1'b0;
        end
    endtask

    // credit return, one pulse per owed report
    always @(posedge clk_adc) begin
        if (!hold_credits && owed > 0) begin
            credit_i <= 1'b1;
            owed = owed - 1;
        end else begin
            credit_i <= 1'b0;
        end
    end

    // compare process, samples away from the rising edge
    initial begin : compare
        int               n;
        prbs_pkg::count_t e_sum;
        prbs_pkg::count_t b_sum;
        forever begin
            @(negedge clk_adc);
            if (reset_check && report_valid_o !== 1'b0) begin
                fail_now("report_valid_o was not low during or right after reset");
            end
            if (rst_n_i === 1'b1 && report_valid_o === 1'b1) begin
                n = int'(frame_count_o);
                if (n == 0 || n > exp_err_q.size()) begin
                    fail_now("a report covers more frames than were checked");
                end
                e_sum = '0;
                b_sum = '0;
                repeat (n) begin
                    e_sum = e_sum + exp_err_q.pop_front();
                    b_sum = b_sum + exp_bits_q.pop_front();
                end
                check_count("err_count_o", e_sum, err_count_o);
                check_count("bit_count_o", b_sum, bit_count_o);
                if (exact_window) begin
                    check_frames("frame_count_o", prbs_pkg::frame_cnt_t'(`WINDOW_FRAMES),
                                 frame_count_o);
                    check_count("err_count_o", '0, err_count_o);
                    check_count("bit_count_o", prbs_pkg::count_t'(`WINDOW_FRAMES * `NTI),
                                bit_count_o);
                end
                if (expect_big) begin
                    if (frame_count_o <= prbs_pkg::frame_cnt_t'(`WINDOW_FRAMES)) begin
                        fail_now("the delayed report did not cover more than one window");
                    end
                    expect_big = 1'b0;
                end
                if (hold_credits) begin
                    hold_reports++;
                end
                total_err_reported += int'(err_count_o);
                owed = owed + 1;
            end
        end
    end

    initial begin
        #(TIME_LIMIT);
        fail_now("timeout: the run did not finish in the expected time");
    end

    initial begin
        rng                = 32'd27;
        gen_hist           = 7'h5b;
        offset_val         = 5;
        thresh_val         = -3;
        mask_val           = '1;
        ref_tail           = '0;
        ref_primed         = 1'b0;
        owed               = 0;
        hold_reports       = 0;
        total_err_reported = 0;
        hold_credits       = 1'b0;
        exact_window       = 1'b0;
        expect_big         = 1'b0;
        reset_check        = 1'b1;
        rst_n_i            = 1'b0;
        frame_valid_i      = 1'b0;
        adc_code_i         = '0;
        adc_sign_i         = '0;
        offset_i           = offset_val;
        thresh_i           = thresh_val;
        chan_sel_i         = mask_val;
        credit_i           = 1'b0;

        repeat (3) @(posedge clk_adc);
        rst_n_i <= 1'b1;
        idle(4);
        reset_check = 1'b0;

        // clean stream, every window exact
        exact_window = 1'b1;
        send_frames(P_CLEAN, 1'b0);
        idle(4);
        exact_window = 1'b0;

        // injected errors, all channels
        send_frames(P_INJECT, 1'b1);
        idle(4);

        // partial mask, changed while the pipeline is empty
        mask_val = 16'h0f3c;
        chan_sel_i <= mask_val;
        idle(2);
        send_frames(P_MASKED, 1'b1);
        idle(6);
        wait (owed == 0);

        // credits withheld, then returned
        mask_val = '1;
        chan_sel_i <= mask_val;
        idle(2);
        hold_reports = 0;
        hold_credits = 1'b1;
        send_frames(P_HOLD, 1'b1);
        idle(6);
        if (hold_reports > `CREDITS_INIT) begin
            fail_now("more reports were sent than credits were held");
        end
        expect_big = 1'b1;
        hold_credits = 1'b0;
        wait (expect_big == 1'b0);

        send_frames(P_RELEASE, 1'b0);
        idle(10);

        if (exp_err_q.size() >= `WINDOW_FRAMES) begin
            fail_now("a full window of frames was left without a report");
        end else if (total_err_reported == 0) begin
            fail_now("no injected error showed up in any report");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule
